/* logic/rf_consts.svh */
// Widths of the instruction, register address and data words
// Sizes of the integer and fp register banks
// Width of the opcode field and of the LI immediate

`ifndef RF_CONSTS_SVH
`define RF_CONSTS_SVH

// Address 0-31 integer bank, 32-63 fp bank
`define RF_ADDR_W    6
`define RF_DATA_W    32

// Bank sizes, word 0 of the integer bank is hard zero
`define RF_INT_WORDS 32
`define RF_FP_WORDS  32

// Instruction word and its fields
`define INSTR_W      32
`define OPCODE_W     4
`define LI_IMM_W     16

`endif

/* logic/isa_pkg.sv */
// Instruction format of the operand-stage datapath
// Opcode enumeration, field layout struct and decoded operation struct

`include "rf_consts.svh"

package isa_pkg;

  // Opcode encodings, any other code decodes as NOP
  typedef enum logic [`OPCODE_W-1:0] {
    OP_NOP  = 4'h0,
    OP_ADD  = 4'h1,
    OP_SUB  = 4'h2,
    OP_AND  = 4'h3,
    OP_OR   = 4'h4,
    OP_XOR  = 4'h5,
    OP_MADD = 4'h6,
    OP_LI   = 4'h7,
    OP_MV   = 4'h8
  } opcode_e;

  // --------------------
  // Instruction layout, msb first
  // LI immediate sits in the low 16 bits over rs2, rs3 and spare
  typedef struct packed {
    logic [`OPCODE_W-1:0]                          op;
    logic [`RF_ADDR_W-1:0]                         rd;
    logic [`RF_ADDR_W-1:0]                         rs1;
    logic [`RF_ADDR_W-1:0]                         rs2;
    logic [`RF_ADDR_W-1:0]                         rs3;
    logic [`INSTR_W-`OPCODE_W-4*`RF_ADDR_W-1:0]    spare;
  } instr_t;

  // --------------------
  // Operation handed from decoder to execution unit
  typedef struct packed {
    opcode_e                op;
    logic [`RF_ADDR_W-1:0]  rd;
    // Zero-extended in the execution unit
    logic [`LI_IMM_W-1:0]   imm;
    logic                   valid;
  } dec_op_t;

endpackage

/* logic/rf_pkg.sv */
// Register file port types
// Address type, write port struct, read address and read data bundles

`include "rf_consts.svh"

package rf_pkg;

  // Top bit picks the fp bank
  typedef logic [`RF_ADDR_W-1:0] rf_addr_t;

  // One write port, we doubles as the strobe
  typedef struct packed {
    logic                   we;
    rf_addr_t               addr;
    logic [`RF_DATA_W-1:0]  data;
  } rf_wport_t;

  // --------------------
  // Three read ports, a=rs1 b=rs2 c=rs3
  typedef struct packed {
    rf_addr_t  a;
    rf_addr_t  b;
    rf_addr_t  c;
  } rf_raddr_t;

  typedef struct packed {
    logic [`RF_DATA_W-1:0]  a;
    logic [`RF_DATA_W-1:0]  b;
    logic [`RF_DATA_W-1:0]  c;
  } rf_rdata_t;

endpackage

/* logic/instr_decoder.sv */
// Instruction decoder
// Splits the instruction into fields, filters unknown opcodes,
// registers read addresses and the decoded operation

`timescale 1ns/1ps

`include "rf_consts.svh"

module instr_decoder (
  input  logic                 clk,
  input  logic                 rst_n,
  // Instruction strobe, taken every cycle it is high
  input  logic                 instr_valid_i,
  input  logic [`INSTR_W-1:0]  instr_i,
  // Registered decode results
  output rf_pkg::rf_raddr_t    raddr_o,
  output isa_pkg::dec_op_t     op_o
);

  import isa_pkg::*;
  import rf_pkg::*;

  instr_t     fields;
  logic       op_known;
  dec_op_t    op_d;
  rf_raddr_t  raddr_d;
  dec_op_t    op_q;
  rf_raddr_t  raddr_q;

  // Field split, immediate overlaps the low fields
  assign fields = instr_t'(instr_i);

  // --------------------
  // Opcode check
  always_comb begin : opcode_check
    case (fields.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
      OP_MADD, OP_LI, OP_MV: op_known = 1'b1;
      // NOP and unused codes produce no result
      default:               op_known = 1'b0;
    endcase
  end

  // Next decoded operation
  always_comb begin : op_build
    op_d.op    = op_known ? opcode_e'(fields.op) : OP_NOP;
    op_d.rd    = fields.rd;
    op_d.imm   = instr_i[`LI_IMM_W-1:0];
    // Strobe only survives for a known opcode
    op_d.valid = instr_valid_i & op_known;
  end

  // Read addresses go straight from the fields
  assign raddr_d = '{a: fields.rs1, b: fields.rs2, c: fields.rs3};

  // --------------------
  // Decode register, strobe becomes a one-cycle valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_q    <= '0;
      // Address 0 keeps idle reads at zero after reset
      raddr_q <= '0;
    end else begin
      op_q    <= op_d;
      raddr_q <= raddr_d;
    end
  end

  assign op_o    = op_q;
  assign raddr_o = raddr_q;

endmodule

/* logic/register_file.sv */
// Flip-flop register file, 3 read ports and 2 write ports
// Integer bank with hard-zero word 0, fp bank on address bit 5
// Port B has priority over port A on the same word

`timescale 1ns/1ps

`include "rf_consts.svh"

module register_file (
  input  logic               clk,
  input  logic               rst_n,
  // Combinational reads
  input  rf_pkg::rf_raddr_t  raddr_i,
  output rf_pkg::rf_rdata_t  rdata_o,
  // Write-back from the execution unit
  input  rf_pkg::rf_wport_t  wport_a_i,
  // External load, wins over port A
  input  rf_pkg::rf_wport_t  wport_b_i
);

  import rf_pkg::*;

  localparam int unsigned TOT_WORDS = `RF_INT_WORDS + `RF_FP_WORDS;
  localparam int unsigned BANK_BIT  = `RF_ADDR_W - 1;

  // Integer bank has no storage for word 0
  logic [`RF_DATA_W-1:0]  mem_int [1:`RF_INT_WORDS-1];
  logic [`RF_DATA_W-1:0]  mem_fp  [0:`RF_FP_WORDS-1];

  // One-hot write enables over both banks, fp words above the integer ones
  logic [TOT_WORDS-1:0]   we_a_dec;
  logic [TOT_WORDS-1:0]   we_b_dec;

  // --------------------
  // Read mux for one port
  function automatic logic [`RF_DATA_W-1:0] read_word(input rf_addr_t addr);
    logic [BANK_BIT-1:0] idx;
    idx = addr[BANK_BIT-1:0];
    if (addr[BANK_BIT]) begin
      return mem_fp[idx];
    end else if (idx == '0) begin
      // Zero register
      return '0;
    end else begin
      return mem_int[idx];
    end
  endfunction

  assign rdata_o.a = read_word(raddr_i.a);
  assign rdata_o.b = read_word(raddr_i.b);
  assign rdata_o.c = read_word(raddr_i.c);

  // --------------------
  // Write address decoder, same for both ports
  function automatic logic [TOT_WORDS-1:0] decode_we(input rf_wport_t wp);
    logic [TOT_WORDS-1:0] dec;
    for (int i = 0; i < TOT_WORDS; i++) begin
      dec[i] = wp.we && (wp.addr == rf_addr_t'(i));
    end
    return dec;
  endfunction

  assign we_a_dec = decode_we(wport_a_i);
  assign we_b_dec = decode_we(wport_b_i);

  // --------------------
  // Integer words 1 and up, writes to word 0 fall away
  for (genvar i = 1; i < `RF_INT_WORDS; i++) begin : gen_int_words
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem_int[i] <= '0;
      end else if (we_b_dec[i]) begin
        mem_int[i] <= wport_b_i.data;
      end else if (we_a_dec[i]) begin
        mem_int[i] <= wport_a_i.data;
      end
    end
  end

  // Fp words, enables offset by the integer bank size
  for (genvar l = 0; l < `RF_FP_WORDS; l++) begin : gen_fp_words
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem_fp[l] <= '0;
      end else if (we_b_dec[l + `RF_INT_WORDS]) begin
        mem_fp[l] <= wport_b_i.data;
      end else if (we_a_dec[l + `RF_INT_WORDS]) begin
        mem_fp[l] <= wport_a_i.data;
      end
    end
  end

endmodule

/* logic/exec_unit.sv */
// Execution unit
// Forwards the pending write-back onto operands, computes the
// result per opcode, registers it for write-back and output

`timescale 1ns/1ps

`include "rf_consts.svh"

module exec_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  // Decoded operation and its read addresses
  input  isa_pkg::dec_op_t       op_i,
  input  rf_pkg::rf_raddr_t      raddr_i,
  // Operands from the register file
  input  rf_pkg::rf_rdata_t      rdata_i,
  // Write-back through port A
  output rf_pkg::rf_wport_t      wport_o,
  // Result seen at the top level
  output logic                   result_valid_o,
  output logic [`RF_DATA_W-1:0]  result_o,
  output rf_pkg::rf_addr_t       result_rd_o
);

  import isa_pkg::*;
  import rf_pkg::*;

  // Result register, also the pending write-back
  logic                   res_valid_q;
  rf_addr_t               res_rd_q;
  logic [`RF_DATA_W-1:0]  res_data_q;

  // Operands after forwarding
  logic [`RF_DATA_W-1:0]  opnd_a;
  logic [`RF_DATA_W-1:0]  opnd_b;
  logic [`RF_DATA_W-1:0]  opnd_c;
  logic [`RF_DATA_W-1:0]  alu_res;

  // --------------------
  // Forwarding
  // The register file only sees the pending result one edge later
  function automatic logic fwd_hit(input rf_addr_t addr);
    return res_valid_q && (res_rd_q == addr) && (addr != '0);
  endfunction

  always_comb begin : operand_fwd
    opnd_a = fwd_hit(raddr_i.a) ? res_data_q : rdata_i.a;
    opnd_b = fwd_hit(raddr_i.b) ? res_data_q : rdata_i.b;
    opnd_c = fwd_hit(raddr_i.c) ? res_data_q : rdata_i.c;
  end

  // --------------------
  // Arithmetic
  always_comb begin : alu
    case (op_i.op)
      OP_ADD:  alu_res = opnd_a + opnd_b;
      OP_SUB:  alu_res = opnd_a - opnd_b;
      OP_AND:  alu_res = opnd_a & opnd_b;
      OP_OR:   alu_res = opnd_a | opnd_b;
      OP_XOR:  alu_res = opnd_a ^ opnd_b;
      // Low word of rs1*rs2, then plus rs3
      OP_MADD: alu_res = opnd_a * opnd_b + opnd_c;
      OP_LI:   alu_res = {{(`RF_DATA_W-`LI_IMM_W){1'b0}}, op_i.imm};
      OP_MV:   alu_res = opnd_a;
      default: alu_res = '0;
    endcase
  end

  // --------------------
  // Result valid, high for one cycle per operation
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= op_i.valid;
    end
  end

  // Result payload, held while idle
  always_ff @(posedge clk) begin
    if (op_i.valid) begin
      res_rd_q   <= op_i.rd;
      res_data_q <= alu_res;
    end
  end

  // Port A write lands on the next edge
  assign wport_o = '{we: res_valid_q, addr: res_rd_q, data: res_data_q};

  assign result_valid_o = res_valid_q;
  assign result_o       = res_data_q;
  assign result_rd_o    = res_rd_q;

endmodule

/* logic/rf_exec_top.sv */
// Top level of the operand-stage datapath
// Decoder, register file and execution unit wired together

`timescale 1ns/1ps

`include "rf_consts.svh"

module rf_exec_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // Instruction strobe
  input  logic                   instr_valid_i,
  input  logic [`INSTR_W-1:0]    instr_i,
  // External load, goes to write port B
  input  rf_pkg::rf_wport_t      load_i,
  // Registered result, two cycles after the strobe
  output logic                   result_valid_o,
  output logic [`RF_DATA_W-1:0]  result_o,
  output rf_pkg::rf_addr_t       result_rd_o
);

  import isa_pkg::*;
  import rf_pkg::*;

  // Decoder to register file and execution unit
  rf_raddr_t  raddr;
  dec_op_t    dec_op;
  // Register file to execution unit
  rf_rdata_t  rdata;
  // Write-back path
  rf_wport_t  wport_a;

  instr_decoder u_decoder (
    .clk           (clk),
    .rst_n         (rst_n),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .raddr_o       (raddr),
    .op_o          (dec_op)
  );

  register_file u_regfile (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_i   (raddr),
    .rdata_o   (rdata),
    .wport_a_i (wport_a),
    .wport_b_i (load_i)
  );

  exec_unit u_exec (
    .clk            (clk),
    .rst_n          (rst_n),
    .op_i           (dec_op),
    .raddr_i        (raddr),
    .rdata_i        (rdata),
    .wport_o        (wport_a),
    .result_valid_o (result_valid_o),
    .result_o       (result_o),
    .result_rd_o    (result_rd_o)
  );

endmodule

/* test/rf_exec_checker.sv */
// Concurrent checks on the datapath top level
// Result timing after a decoded operation, known result data,
// zero register reads; bound into rf_exec_top

`timescale 1ns/1ps

`include "rf_consts.svh"

module rf_exec_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid_i,
  input  logic                   result_valid_i,
  input  logic [`RF_DATA_W-1:0]  result_i,
  input  rf_pkg::rf_raddr_t      raddr_i,
  input  rf_pkg::rf_rdata_t      rdata_i
);

  import rf_pkg::*;

  // Result exactly one cycle after a valid decoded operation
  result_follows_op: assert property (@(posedge clk) disable iff (!rst_n)
    op_valid_i |=> result_valid_i)
    else $error("result_valid_o missing one cycle after a decoded operation");

  no_stray_result: assert property (@(posedge clk) disable iff (!rst_n)
    !op_valid_i |=> !result_valid_i)
    else $error("result_valid_o high without a decoded operation");

  result_known: assert property (@(posedge clk) disable iff (!rst_n)
    result_valid_i |-> !$isunknown(result_i))
    else $error("result_o has unknown bits while valid");

  // --------------------
  // Register 0 reads zero on every port
  zero_read_a: assert property (@(posedge clk) disable iff (!rst_n)
    (raddr_i.a == rf_addr_t'(0)) |-> (rdata_i.a == '0))
    else $error("read port a returned nonzero for register 0");

  zero_read_b: assert property (@(posedge clk) disable iff (!rst_n)
    (raddr_i.b == rf_addr_t'(0)) |-> (rdata_i.b == '0))
    else $error("read port b returned nonzero for register 0");

  zero_read_c: assert property (@(posedge clk) disable iff (!rst_n)
    (raddr_i.c == rf_addr_t'(0)) |-> (rdata_i.c == '0))
    else $error("read port c returned nonzero for register 0");

endmodule

bind rf_exec_top rf_exec_checker u_checker (
  .clk            (clk),
  .rst_n          (rst_n),
  .op_valid_i     (dec_op.valid),
  .result_valid_i (result_valid_o),
  .result_i       (result_o),
  .raddr_i        (raddr),
  .rdata_i        (rdata)
);

/* test/rf_exec_tb.sv */
// Testbench for the operand-stage datapath
// Reads stimulus and expected results from the patterns file,
// checks each result two cycles after issue, cycle timeout

`timescale 1ns/1ps

`include "rf_consts.svh"

module rf_exec_tb;

  import rf_pkg::*;

  // Expected result of one issue slot
  typedef struct packed {
    logic                   valid;
    logic [`RF_DATA_W-1:0]  data;
    rf_addr_t               rd;
  } exp_t;

  // One line of the patterns file
  typedef struct packed {
    logic [7:0]             kind;
    logic [`INSTR_W-1:0]    instr;
    rf_wport_t              load;
    exp_t                   res;
  } pat_t;

  logic                   clk;
  logic                   rst_n;
  logic                   instr_valid;
  logic [`INSTR_W-1:0]    instr;
  rf_wport_t              load;
  logic                   result_valid;
  logic [`RF_DATA_W-1:0]  result;
  rf_addr_t               result_rd;

  pat_t  pats[$];
  // Results in flight, front entry is due now
  exp_t  exp_q[$];
  int    seed = 51674;
  int    cycle_cnt = 0;
  int    cycle_limit = 0;

  rf_exec_top UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_i        (instr),
    .load_i         (load),
    .result_valid_o (result_valid),
    .result_o       (result),
    .result_rd_o    (result_rd)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1, "stopped at the first error");
  endtask

  // --------------------
  // Patterns file, kind instr load_addr load_data exp_data exp_rd
  task automatic read_patterns();
    int                     fd;
    int                     rc;
    string                  line;
    string                  kind_s;
    string                  exp_s;
    string                  rd_s;
    logic [`INSTR_W-1:0]    iw;
    rf_addr_t               la;
    logic [`RF_DATA_W-1:0]  ld;
    logic [`RF_DATA_W-1:0]  ed;
    rf_addr_t               er;
    pat_t                   p;
    fd = $fopen("test/rf_exec_patterns.txt", "r");
    if (fd == 0) fail_run("could not open test/rf_exec_patterns.txt");
    while (!$feof(fd)) begin
      rc = $fgets(line, fd);
      // Blank and comment lines
      if (rc < 2 || line[0] == "#") continue;
      rc = $sscanf(line, "%s %h %h %h %s %s", kind_s, iw, la, ld, exp_s, rd_s);
      if (rc != 6) fail_run("malformed line in the patterns file");
      p = '0;
      p.kind = kind_s[0];
      p.instr = iw;
      p.load.we = (kind_s == "L");
      p.load.addr = la;
      p.load.data = ld;
      if (exp_s != "-") begin
        rc = $sscanf(exp_s, "%h", ed);
        rc = $sscanf(rd_s, "%h", er);
        p.res = '{valid: 1'b1, data: ed, rd: er};
      end
      pats.push_back(p);
    end
    $fclose(fd);
  endtask

  // --------------------
  // Compare outputs with one expected slot
  task automatic check_slot(input exp_t e);
    if (e.valid) begin
      assert (result_valid === 1'b1) else fail_run($sformatf(
        "Error at time %0t: result_valid_o expected 1, got %b", $time, result_valid));
      assert (result === e.data) else fail_run($sformatf(
        "Error at time %0t: result_o expected %h, got %h", $time, e.data, result));
      assert (result_rd === e.rd) else fail_run($sformatf(
        "Error at time %0t: result_rd_o expected %h, got %h", $time, e.rd, result_rd));
    end else begin
      assert (result_valid === 1'b0) else fail_run($sformatf(
        "Error at time %0t: result_valid_o expected 0, got %b", $time, result_valid));
    end
  endtask

  // Drive one slot, then check the slot issued two cycles before
  task automatic run_cycle(input pat_t p);
    instr_valid = (p.kind == "I");
    instr = p.instr;
    load = p.load;
    exp_q.push_back(p.res);
    @(posedge clk);
    #2;
    check_slot(exp_q.pop_front());
  endtask

  initial begin : stimulus
    int gap;
    rst_n = 1'b0;
    instr_valid = 1'b0;
    instr = '0;
    load = '0;
    read_patterns();
    // Reset, at most 3 cycles per line, drain and margin
    cycle_limit = 10 + 4 * pats.size() + 20;
    repeat (10) begin
      @(posedge clk);
      #2;
      check_slot('0);
    end
    rst_n = 1'b1;
    // Nothing in flight ahead of the first issue
    exp_q.push_back('0);
    foreach (pats[i]) begin
      if (pats[i].kind == "N") begin
        // Idle line stretches by 0 to 2 random cycles
        gap = $unsigned($random(seed)) % 3;
        repeat (gap + 1) run_cycle('0);
      end else begin
        run_cycle(pats[i]);
      end
    end
    // Last result, then no stray valid
    repeat (3) run_cycle('0);
    $display("Regression passed");
    $finish;
  end

  always @(posedge clk) begin : watchdog
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      fail_run("timeout: results did not finish");
    end
  end

endmodule

/* test/rf_exec_patterns.txt */
# kind instr ld_addr ld_data exp_data exp_rd, all hex
# kind I issue, L load, N idle run; a dash where no result is expected
I 80470000 00 00000000 00000000 01
I 70801234 00 00000000 00001234 02
I 70C000F0 00 00000000 000000F0 03
I 11020C00 00 00000000 00001324 04
I 21440800 00 00000000 000000F0 05
N 00000000 00 00000000 - -
I 31821000 00 00000000 00001224 06
I 41C21000 00 00000000 00001334 07
I 52061C00 00 00000000 00000110 08
I 62420C80 00 00000000 001111D0 09
I F2420C80 00 00000000 - -
I 00000000 00 00000000 - -
N 00000000 00 00000000 - -
I 70005555 00 00000000 00005555 00
I 82800000 00 00000000 00000000 0A
I 7840BEEF 00 00000000 0000BEEF 21
I 82C10000 00 00000000 00000000 0B
I 18A10800 00 00000000 0000D123 22
N 00000000 00 00000000 - -
L 00000000 0C CAFE0001 - -
I 834C0000 00 00000000 CAFE0001 0D
N 00000000 00 00000000 - -
I 71400AAA 00 00000000 00000AAA 05
I 73800001 00 00000000 00000001 0E
L 00000000 05 600DF00D - -
N 00000000 00 00000000 - -
I 83C50000 00 00000000 600DF00D 0F

/* sources.f */
+incdir+logic
logic/isa_pkg.sv
logic/rf_pkg.sv
logic/instr_decoder.sv
logic/register_file.sv
logic/exec_unit.sv
logic/rf_exec_top.sv
test/rf_exec_checker.sv
test/rf_exec_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the datapath simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f sources.f --top-module rf_exec_tb \
  -Mdir obj_dir -o rf_exec_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/rf_exec_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation ended with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
